// File: hdl/mac_table_pkg.sv
package mac_table_pkg;

  // ========================================
  // table geometry
  // ========================================
  // bucket index width, 1024 buckets
  localparam int ADDR_W = 10;
  localparam int DEPTH  = 1 << ADDR_W;
  localparam int MAC_W  = 48;
  localparam int PORT_W = 16;
  localparam int LIVE_W = 10;

  // crc-10 generator, x^10+x^9+x^5+x^4+x+1
  localparam logic [ADDR_W-1:0] CRC_POLY = 10'h233;

  // ========================================
  // aging
  // ========================================
  // live time loaded on learn or refresh
  localparam logic [LIVE_W-1:0] LIVE_TH = 10'd4;
  // idle cycles between two sweeps
  localparam int AGE_GAP = 64;
  localparam int GAP_W   = $clog2(AGE_GAP + 1);

  // request opcode
  typedef enum logic {
    SE_LOOKUP = 1'b0,
    SE_LEARN  = 1'b1
  } se_op_e;

  // bucket engine FSM
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_READ,
    ST_COMPARE,
    ST_LEARN_DECIDE,
    ST_LEARN_NEW,
    ST_REFRESH,
    ST_LOOKUP,
    ST_AGE_RD0,
    ST_AGE_RD1,
    ST_AGE_WR,
    ST_DONE,
    ST_CLEAR
  } bucket_state_e;

  // tag ram word, 16 bits
  typedef struct packed {
    logic              valid;
    logic [4:0]        rsvd;
    logic [LIVE_W-1:0] live;
  } tag_t;

  // data ram word, 64 bits
  typedef struct packed {
    logic [PORT_W-1:0] portmap;
    logic [MAC_W-1:0]  mac;
  } data_t;

  // client request, hash travels separately
  typedef struct packed {
    se_op_e            op;
    logic [MAC_W-1:0]  mac;
    logic [PORT_W-1:0] portmap;
  } se_req_t;

  // client response
  typedef struct packed {
    logic              ack;
    logic              nak;
    logic [PORT_W-1:0] result;
  } se_rsp_t;

endpackage

// File: hdl/sram_sp.sv
`timescale 1ns/1ps

module sram_sp #(
  parameter int WIDTH = 16
) (
  input  logic                             clk,
  input  logic                             we,
  input  logic [mac_table_pkg::ADDR_W-1:0] addr,
  input  logic [WIDTH-1:0]                 din,
  output logic [WIDTH-1:0]                 dout
);
  import mac_table_pkg::*;

  // one word per bucket
  logic [WIDTH-1:0] mem [DEPTH];

  // write and registered read share the port
  // read of a written address returns the old word
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];
  end

endmodule

// File: hdl/mac_hash.sv
`timescale 1ns/1ps

module mac_hash (
  input  logic [mac_table_pkg::MAC_W-1:0]  mac,
  output logic [mac_table_pkg::ADDR_W-1:0] hash
);
  import mac_table_pkg::*;

  // running remainder
  logic [ADDR_W-1:0] crc;
  // msb of remainder xor input bit
  logic              fb;

  // ========================================
  // serial crc-10, unrolled by the loop
  // ========================================
  always_comb begin
    // init value zero
    crc = '0;
    fb  = 1'b0;
    // msb of the mac goes in first
    for (int i = MAC_W - 1; i >= 0; i--) begin
      fb  = crc[ADDR_W-1] ^ mac[i];
      crc = {crc[ADDR_W-2:0], 1'b0};
      if (fb) begin
        crc = crc ^ CRC_POLY;
      end
    end
    // final remainder is the bucket
    hash = crc;
  end

endmodule

// File: hdl/aging_timer.sv
`timescale 1ns/1ps

module aging_timer (
  input  logic clk,
  input  logic rstn,
  input  logic age_en,
  input  logic aging_ack,
  output logic aging_req
);
  import mac_table_pkg::*;

  // cycles left before the next sweep may start
  logic [GAP_W-1:0] gap_cnt;
  // a sweep is running
  logic             sweep_active;

  // ========================================
  // sweep pacing
  // ========================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      gap_cnt      <= '0;
      sweep_active <= 1'b0;
    end else if (sweep_active) begin
      // last bucket aged, start the gap
      if (aging_ack) begin
        sweep_active <= 1'b0;
        gap_cnt      <= GAP_W'(AGE_GAP);
      end
    end else if (gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end else if (age_en) begin
      // age_en only gates the start of a sweep
      sweep_active <= 1'b1;
    end
  end

  // held through the whole sweep
  assign aging_req = sweep_active;

endmodule

// File: hdl/hash_2_bucket.sv
`timescale 1ns/1ps

module hash_2_bucket (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             se_req,
  input  mac_table_pkg::se_req_t           se_cmd,
  input  logic [mac_table_pkg::ADDR_W-1:0] se_hash,
  output mac_table_pkg::se_rsp_t           se_rsp,
  input  logic                             aging_req,
  output logic                             aging_ack
);
  import mac_table_pkg::*;

  bucket_state_e state;

  // second read cycle flag
  logic rd_cnt;
  // sweep address, also walks the table on clear
  logic [ADDR_W-1:0] sweep_addr;
  // latched request
  se_req_t req_q;
  // registered per-way hit
  logic [1:0] hit;

  // ram ports, index is the way
  logic [1:0][ADDR_W-1:0] ram_addr;
  logic [1:0]             tag_we;
  logic [1:0]             data_we;
  tag_t [1:0]             tag_din;
  data_t [1:0]            data_din;
  tag_t [1:0]             tag_dout;
  data_t [1:0]            data_dout;

  // compare results
  logic [1:0] mac_lo_eq;
  logic [1:0] mac_hi_eq;
  logic [1:0] hit_now;
  // tag values for learn and aging writes
  tag_t       learn_tag;
  data_t      learn_data;
  tag_t [1:0] aged_tag;

  // ========================================
  // per-way compare and aging
  // ========================================
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      // mac split in two 24-bit halves
      mac_lo_eq[w] = req_q.mac[23:0] == data_dout[w].mac[23:0];
      mac_hi_eq[w] = req_q.mac[47:24] == data_dout[w].mac[47:24];
      hit_now[w]   = tag_dout[w].valid & mac_lo_eq[w] & mac_hi_eq[w];
      // expired entry drops valid, empty entry stays empty
      aged_tag[w].valid = tag_dout[w].valid & (tag_dout[w].live != '0);
      aged_tag[w].rsvd  = '0;
      aged_tag[w].live  = tag_dout[w].live - 1'b1;
    end
  end

  // fresh entry from the latched request
  assign learn_tag  = '{valid: 1'b1, rsvd: 5'd0, live: LIVE_TH};
  assign learn_data = '{portmap: req_q.portmap, mac: req_q.mac};

  // ========================================
  // main FSM
  // ========================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= ST_CLEAR;
      rd_cnt     <= 1'b0;
      sweep_addr <= '0;
      hit        <= '0;
      tag_we     <= '0;
      data_we    <= '0;
      se_rsp     <= '0;
      aging_ack  <= 1'b0;
    end else begin
      // single-cycle pulses
      tag_we        <= '0;
      data_we       <= '0;
      se_rsp.ack    <= 1'b0;
      se_rsp.nak    <= 1'b0;
      aging_ack     <= 1'b0;
      case (state)
        // clear ends before idle, so requests wait here
        ST_IDLE: begin
          if (se_req) begin
            ram_addr <= {2{se_hash}};
            req_q    <= se_cmd;
            rd_cnt   <= 1'b0;
            state    <= ST_READ;
          end else if (aging_req) begin
            ram_addr   <= {2{sweep_addr}};
            sweep_addr <= sweep_addr + 1'b1;
            // last bucket of the sweep
            if (&sweep_addr) begin
              aging_ack <= 1'b1;
            end
            state <= ST_AGE_RD0;
          end
        end
        // address out, then ram latency
        ST_READ: begin
          rd_cnt <= 1'b1;
          if (rd_cnt) begin
            state <= ST_COMPARE;
          end
        end
        ST_COMPARE: begin
          hit <= hit_now;
          if (req_q.op == SE_LEARN) begin
            state <= ST_LEARN_DECIDE;
          end else begin
            state <= ST_LOOKUP;
          end
        end
        // known mac refreshes, new mac takes a free way
        ST_LEARN_DECIDE: begin
          if (|hit) begin
            state <= ST_REFRESH;
          end else begin
            state <= ST_LEARN_NEW;
          end
        end
        ST_LEARN_NEW: begin
          tag_din  <= {2{learn_tag}};
          data_din <= {2{learn_data}};
          // way 0 first
          if (!tag_dout[0].valid) begin
            tag_we[0]  <= 1'b1;
            data_we[0] <= 1'b1;
            se_rsp.ack <= 1'b1;
          end else if (!tag_dout[1].valid) begin
            tag_we[1]  <= 1'b1;
            data_we[1] <= 1'b1;
            se_rsp.ack <= 1'b1;
          end else begin
            // bucket full
            se_rsp.nak <= 1'b1;
          end
          state <= ST_DONE;
        end
        ST_REFRESH: begin
          tag_din    <= {2{learn_tag}};
          data_din   <= {2{learn_data}};
          se_rsp.ack <= 1'b1;
          if (hit[0]) begin
            tag_we[0]  <= 1'b1;
            data_we[0] <= 1'b1;
          end else begin
            tag_we[1]  <= 1'b1;
            data_we[1] <= 1'b1;
          end
          state <= ST_DONE;
        end
        // data ram output still holds the bucket
        ST_LOOKUP: begin
          if (hit[0]) begin
            se_rsp.ack    <= 1'b1;
            se_rsp.result <= data_dout[0].portmap;
          end else if (hit[1]) begin
            se_rsp.ack    <= 1'b1;
            se_rsp.result <= data_dout[1].portmap;
          end else begin
            se_rsp.nak <= 1'b1;
          end
          state <= ST_DONE;
        end
        // ================ aging step ================
        ST_AGE_RD0: begin
          state <= ST_AGE_RD1;
        end
        ST_AGE_RD1: begin
          state <= ST_AGE_WR;
        end
        // only tags are rewritten
        ST_AGE_WR: begin
          tag_din <= aged_tag;
          tag_we  <= 2'b11;
          state   <= ST_DONE;
        end
        // writes land here, request drops here
        ST_DONE: begin
          hit   <= '0;
          state <= ST_IDLE;
        end
        // zero tag per bucket, both ways at once
        ST_CLEAR: begin
          ram_addr   <= {2{sweep_addr}};
          tag_din    <= '0;
          tag_we     <= 2'b11;
          sweep_addr <= sweep_addr + 1'b1;
          if (&sweep_addr) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ========================================
  // tag and data rams per way
  // ========================================
  for (genvar w = 0; w < 2; w++) begin : gen_way
    sram_sp #(
      .WIDTH($bits(tag_t))
    ) u_tag_ram (
      .clk  (clk),
      .we   (tag_we[w]),
      .addr (ram_addr[w]),
      .din  (tag_din[w]),
      .dout (tag_dout[w])
    );

    sram_sp #(
      .WIDTH($bits(data_t))
    ) u_data_ram (
      .clk  (clk),
      .we   (data_we[w]),
      .addr (ram_addr[w]),
      .din  (data_din[w]),
      .dout (data_dout[w])
    );
  end

endmodule

// File: hdl/mac_table.sv
`timescale 1ns/1ps

module mac_table (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   se_req,
  input  mac_table_pkg::se_req_t se_cmd,
  output mac_table_pkg::se_rsp_t se_rsp,
  input  logic                   age_en,
  output logic                   sweep_done
);
  import mac_table_pkg::*;

  // bucket of the requested mac
  logic [ADDR_W-1:0] se_hash;
  // aging handshake
  logic              aging_req;
  logic              aging_ack;

  // ========================================
  // hash, pacing and bucket engine
  // ========================================
  mac_hash u_mac_hash (
    .mac  (se_cmd.mac),
    .hash (se_hash)
  );

  aging_timer u_aging_timer (
    .clk       (clk),
    .rstn      (rstn),
    .age_en    (age_en),
    .aging_ack (aging_ack),
    .aging_req (aging_req)
  );

  hash_2_bucket u_hash_2_bucket (
    .clk       (clk),
    .rstn      (rstn),
    .se_req    (se_req),
    .se_cmd    (se_cmd),
    .se_hash   (se_hash),
    .se_rsp    (se_rsp),
    .aging_req (aging_req),
    .aging_ack (aging_ack)
  );

  // one pulse per finished sweep
  assign sweep_done = aging_ack;

endmodule

// File: dv/mac_table_tb.sv
`timescale 1ns/1ps

module mac_table_tb;
  import mac_table_pkg::*;

  // per request, covers the reset clear and a few aging steps
  localparam int OP_TIMEOUT    = 2 * DEPTH;
  // one sweep of five-cycle steps plus the gap, with slack
  localparam int SWEEP_TIMEOUT = DEPTH * 6 + AGE_GAP + 200;
  // clear, 8 sweeps and margin
  localparam int WD_CYCLES     = DEPTH + 8 * (DEPTH * (5 + 1) + AGE_GAP) + 5000;

  logic    clk;
  logic    rstn;
  logic    se_req;
  se_req_t se_cmd;
  se_rsp_t se_rsp;
  logic    age_en;
  logic    sweep_done;

  int                n_checks;
  int                n_errors;
  // buckets already given to a drawn mac
  bit [DEPTH-1:0]    bucket_used;
  logic [MAC_W-1:0]  mac_list [8];
  logic [PORT_W-1:0] pmap_list [8];
  // result the DUT should still be holding
  logic [PORT_W-1:0] held_result;

  mac_table mac_table_i (
    .clk        (clk),
    .rstn       (rstn),
    .se_req     (se_req),
    .se_cmd     (se_cmd),
    .se_rsp     (se_rsp),
    .age_en     (age_en),
    .sweep_done (sweep_done)
  );

  always #5 clk = ~clk;

  // ========================================
  // reference model and stimulus helpers
  // ========================================
  // bucket index, crc-10 poly 0x233, zero init, mac bit 47 first
  function automatic logic [ADDR_W-1:0] crc10(input logic [MAC_W-1:0] mac);
    logic [ADDR_W-1:0] r;
    logic              b;
    r = '0;
    for (int i = MAC_W - 1; i >= 0; i--) begin
      b = r[ADDR_W-1] ^ mac[i];
      r = {r[ADDR_W-2:0], 1'b0} ^ (b ? 10'h233 : 10'h000);
    end
    return r;
  endfunction

  function automatic logic [MAC_W-1:0] rand_mac();
    return {16'($urandom), $urandom};
  endfunction

  // mac landing in a bucket no other test touches
  task automatic draw_free_mac(output logic [MAC_W-1:0] mac);
    mac = rand_mac();
    while (bucket_used[crc10(mac)]) begin
      mac = rand_mac();
    end
    bucket_used[crc10(mac)] = 1'b1;
  endtask

  // about 1024 draws per hit
  task automatic draw_mac_in_bucket(input logic [ADDR_W-1:0] bkt, output logic [MAC_W-1:0] mac);
    mac = rand_mac();
    while (crc10(mac) != bkt) begin
      mac = rand_mac();
    end
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // ========================================
  // client handshake
  // ========================================
  // entered and left 1 ns after a rising edge
  task automatic se_op(input se_op_e op, input logic [MAC_W-1:0] mac,
                       input logic [PORT_W-1:0] pmap, output logic ack, output logic nak,
                       output logic [PORT_W-1:0] result);
    int waited;
    waited = 0;
    se_cmd = '{op: op, mac: mac, portmap: pmap};
    se_req = 1'b1;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!(se_rsp.ack || se_rsp.nak) && waited < OP_TIMEOUT);
    ack    = se_rsp.ack;
    nak    = se_rsp.nak;
    result = se_rsp.result;
    n_checks++;
    assert (ack || nak) else begin
      n_errors++;
      $display("no response to %s of mac %h after %0d cycles", op.name(), mac, waited);
    end
    n_checks++;
    assert (!(ack && nak)) else begin
      n_errors++;
      $display("ack and nak both set for %s of mac %h", op.name(), mac);
    end
    // drop the request while the engine sits in its done state
    se_req = 1'b0;
    @(posedge clk);
    #1;
    n_checks++;
    assert (!se_rsp.ack && !se_rsp.nak) else begin
      n_errors++;
      $display("response to %s of mac %h lasted more than one cycle", op.name(), mac);
    end
  endtask

  task automatic learn_expect(input logic [MAC_W-1:0] mac, input logic [PORT_W-1:0] pmap,
                              input logic exp_ack);
    logic              ack;
    logic              nak;
    logic [PORT_W-1:0] res;
    se_op(SE_LEARN, mac, pmap, ack, nak, res);
    check_eq($sformatf("se_rsp.ack, learn %h", mac), ack, exp_ack);
    check_eq($sformatf("se_rsp.nak, learn %h", mac), nak, !exp_ack);
    // a learn leaves the last lookup result alone
    check_eq("se_rsp.result", res, held_result);
  endtask

  task automatic lookup_expect(input logic [MAC_W-1:0] mac, input logic exp_hit,
                               input logic [PORT_W-1:0] exp_pmap);
    logic              ack;
    logic              nak;
    logic [PORT_W-1:0] res;
    se_op(SE_LOOKUP, mac, '0, ack, nak, res);
    check_eq($sformatf("se_rsp.ack, lookup %h", mac), ack, exp_hit);
    check_eq($sformatf("se_rsp.nak, lookup %h", mac), nak, !exp_hit);
    if (exp_hit) begin
      held_result = exp_pmap;
    end
    check_eq($sformatf("se_rsp.result, lookup %h", mac), res, held_result);
  endtask

  task automatic wait_sweeps(input int n);
    int waited;
    for (int s = 0; s < n; s++) begin
      waited = 0;
      do begin
        @(posedge clk);
        #1;
        waited++;
      end while (!sweep_done && waited < SWEEP_TIMEOUT);
      n_checks++;
      assert (sweep_done) else begin
        n_errors++;
        $display("no sweep_done pulse within %0d cycles", SWEEP_TIMEOUT);
      end
    end
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic learn_then_lookup();
    for (int i = 0; i < 8; i++) begin
      draw_free_mac(mac_list[i]);
      pmap_list[i] = 16'($urandom);
      learn_expect(mac_list[i], pmap_list[i], 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      lookup_expect(mac_list[i], 1'b1, pmap_list[i]);
    end
  endtask

  task automatic lookup_miss();
    logic [MAC_W-1:0] mac;
    draw_free_mac(mac);
    lookup_expect(mac, 1'b0, '0);
  endtask

  task automatic refresh_entry();
    pmap_list[2] = ~pmap_list[2];
    learn_expect(mac_list[2], pmap_list[2], 1'b1);
    lookup_expect(mac_list[2], 1'b1, pmap_list[2]);
  endtask

  // three macs in one bucket, only two ways
  task automatic bucket_overflow();
    logic [MAC_W-1:0]  mac_a;
    logic [MAC_W-1:0]  mac_b;
    logic [MAC_W-1:0]  mac_c;
    logic [PORT_W-1:0] pmap_a;
    logic [PORT_W-1:0] pmap_b;
    draw_free_mac(mac_a);
    draw_mac_in_bucket(crc10(mac_a), mac_b);
    draw_mac_in_bucket(crc10(mac_a), mac_c);
    pmap_a = 16'($urandom);
    pmap_b = 16'($urandom);
    learn_expect(mac_a, pmap_a, 1'b1);
    learn_expect(mac_b, pmap_b, 1'b1);
    learn_expect(mac_c, 16'($urandom), 1'b0);
    lookup_expect(mac_a, 1'b1, pmap_a);
    lookup_expect(mac_b, 1'b1, pmap_b);
    lookup_expect(mac_c, 1'b0, '0);
  endtask

  // live 4 survives four sweeps, the fifth drops valid
  task automatic aging_expiry();
    logic [MAC_W-1:0]  mac_a;
    logic [PORT_W-1:0] pmap_a;
    draw_free_mac(mac_a);
    pmap_a = 16'($urandom);
    learn_expect(mac_a, pmap_a, 1'b1);
    age_en = 1'b1;
    wait_sweeps(3);
    // refresh reloads live in the gap
    pmap_list[1] = pmap_list[1] ^ 16'h00ff;
    learn_expect(mac_list[1], pmap_list[1], 1'b1);
    wait_sweeps(1);
    lookup_expect(mac_a, 1'b1, pmap_a);
    lookup_expect(mac_list[0], 1'b1, pmap_list[0]);
    wait_sweeps(1);
    lookup_expect(mac_a, 1'b0, '0);
    lookup_expect(mac_list[0], 1'b0, '0);
    lookup_expect(mac_list[1], 1'b1, pmap_list[1]);
  endtask

  // ========================================
  // main sequence and watchdog
  // ========================================
  initial begin
    clk         = 1'b0;
    rstn        = 1'b0;
    se_req      = 1'b0;
    se_cmd      = '0;
    age_en      = 1'b0;
    n_checks    = 0;
    n_errors    = 0;
    held_result = '0;
    bucket_used = '0;
    void'($urandom(32'h898f_de56));
    repeat (8) @(posedge clk);
    #1;
    check_eq("se_rsp", se_rsp, '0);
    check_eq("sweep_done", sweep_done, 1'b0);
    rstn = 1'b1;
    // first request waits out the table clear
    learn_then_lookup();
    lookup_miss();
    refresh_entry();
    bucket_overflow();
    aging_expiry();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("timeout, run still going after %0d cycles", WD_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

// File: mac_table.f
hdl/mac_table_pkg.sv
hdl/sram_sp.sv
hdl/mac_hash.sv
hdl/aging_timer.sv
hdl/hash_2_bucket.sv
hdl/mac_table.sv
dv/mac_table_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the mac table testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mac_table_tb \
  -f mac_table.f -o mac_table_sim \
  && ./obj_dir/mac_table_sim | tee /dev/stderr | grep "all tests passed" > /dev/null \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
